// ==== all.f ====
hdl/peripheralPkg.sv
hdl/BusInterfaces.sv
hdl/DeviceSelect.sv
hdl/ConfigurationRegister.sv
hdl/DataRegister.sv
hdl/GPIODevice.sv
hdl/PeripheralSubsystem.sv
tests/PeripheralSubsystemTb_asserts.sv
tests/PeripheralSubsystemTb.sv

// ==== hdl/BusInterfaces.sv ====
// one device's view of the system peripheral bus
interface peripheralBusIf;
	logic enable;
	logic we;
	logic oe;
	peripheralPkg::busAddress_t address;
	peripheralPkg::byteSelect_t byteSelect;
	peripheralPkg::busData_t dataWrite;
	peripheralPkg::busData_t dataRead;
	logic request; // flags dataRead for one cycle

	modport host (
		output enable,
		output we,
		output oe,
		output address,
		output byteSelect,
		output dataWrite,
		input dataRead,
		input request
	);

	modport device (
		input enable,
		input we,
		input oe,
		input address,
		input byteSelect,
		input dataWrite,
		output dataRead,
		output request
	);
endinterface

// register bus inside a device, already decoded to a local offset
interface registerBusIf;
	logic enable;
	logic we;
	logic oe;
	peripheralPkg::localAddress_t localAddress;
	peripheralPkg::byteSelect_t byteSelect;
	peripheralPkg::busData_t dataWrite;

	modport select (
		output enable,
		output we,
		output oe,
		output localAddress,
		output byteSelect,
		output dataWrite
	);

	modport register (
		input enable,
		input we,
		input oe,
		input localAddress,
		input byteSelect,
		input dataWrite
	);
endinterface

// ==== hdl/ConfigurationRegister.sv ====
module ConfigurationRegister #(
	parameter int WIDTH = 32,
	parameter peripheralPkg::localAddress_t ADDRESS = 12'h000,
	parameter logic [WIDTH-1:0] DEFAULT = '0
) (
	input logic clk,
	input logic reset,
	registerBusIf.register localBus,
	output peripheralPkg::busData_t dataRead,
	output logic request,
	output logic [WIDTH-1:0] currentValue
);

	logic addressHit;
	logic writeHit;
	logic readHit;
	peripheralPkg::busData_t laneMask;
	logic [WIDTH-1:0] writeMask;
	logic [WIDTH-1:0] storedValue;

	assign addressHit = localBus.enable && (localBus.localAddress == ADDRESS);
	assign writeHit = addressHit && localBus.we && !localBus.oe;
	assign readHit = addressHit && localBus.oe && !localBus.we;

	// ******************************
	// byte lane write mask
	// ******************************
	always_comb begin
		for (int lane = 0; lane < peripheralPkg::BYTE_LANES; lane++) begin
			laneMask[lane*8 +: 8] = {8{localBus.byteSelect[lane]}};
		end
	end

	assign writeMask = laneMask[WIDTH-1:0]; // lanes above the register width fall away

	always_ff @(posedge clk) begin
		if (reset) begin
			storedValue <= DEFAULT;
		end else if (writeHit) begin
			storedValue <= (storedValue & ~writeMask) |
				(localBus.dataWrite[WIDTH-1:0] & writeMask);
		end
	end

	// ******************************
	// read-back
	// ******************************
	always_ff @(posedge clk) begin
		if (reset) begin
			request <= 1'b0;
		end else begin
			request <= readHit; // one cycle pulse per read
		end
	end

	always_ff @(posedge clk) begin
		if (readHit) begin
			dataRead <= peripheralPkg::busData_t'(storedValue); // zero-extended
		end
	end

	assign currentValue = storedValue;

endmodule

// ==== hdl/DataRegister.sv ====
module DataRegister #(
	parameter int WIDTH = 32,
	parameter peripheralPkg::localAddress_t ADDRESS = 12'h000
) (
	input logic clk,
	input logic reset,
	registerBusIf.register localBus,
	input logic [WIDTH-1:0] readData,
	output logic readEnable,
	output peripheralPkg::busData_t dataRead,
	output logic request
);

	logic readHit;

	// writes to this offset are ignored
	assign readHit = localBus.enable && (localBus.localAddress == ADDRESS) &&
		localBus.oe && !localBus.we;

	assign readEnable = readHit; // lets a source advance in the read cycle

	always_ff @(posedge clk) begin
		if (reset) begin
			request <= 1'b0;
		end else begin
			request <= readHit;
		end
	end

	// the live value is sampled at the read edge
	always_ff @(posedge clk) begin
		if (readHit) begin
			dataRead <= peripheralPkg::busData_t'(readData);
		end
	end

endmodule

// ==== hdl/DeviceSelect.sv ====
module DeviceSelect #(
	parameter peripheralPkg::deviceId_t ID = 4'h0
) (
	peripheralBusIf.device peripheralBus,
	registerBusIf.select localBus
);

	localparam int ID_LSB = peripheralPkg::ADDRESS_WIDTH - peripheralPkg::DEVICE_ID_WIDTH;

	logic idMatch;

	assign idMatch = peripheralBus.address[ID_LSB +: peripheralPkg::DEVICE_ID_WIDTH] == ID;

	assign localBus.enable = peripheralBus.enable && idMatch;
	assign localBus.we = peripheralBus.we;
	assign localBus.oe = peripheralBus.oe;
	assign localBus.localAddress =
		peripheralBus.address[peripheralPkg::LOCAL_ADDRESS_WIDTH-1:0]; // drop the ID nibble
	assign localBus.byteSelect = peripheralBus.byteSelect;
	assign localBus.dataWrite = peripheralBus.dataWrite;

endmodule

// ==== hdl/GPIODevice.sv ====
module GPIODevice #(
	parameter peripheralPkg::deviceId_t ID = 4'h0,
	parameter int IO_COUNT = 16
) (
	input logic clk,
	input logic reset,
	peripheralBusIf.device peripheralBus,
	input logic [IO_COUNT-1:0] gpioInput,
	output logic [IO_COUNT-1:0] gpioOutput,
	output logic [IO_COUNT-1:0] gpioOe
);

	registerBusIf localBus ();

	peripheralPkg::busData_t oeData;
	peripheralPkg::busData_t outputData;
	peripheralPkg::busData_t inputData;
	logic oeRequest;
	logic outputRequest;
	logic inputRequest;

	DeviceSelect #(.ID(ID)) select (
		.peripheralBus(peripheralBus),
		.localBus(localBus)
	);

	// ******************************
	// registers
	// ******************************
	ConfigurationRegister #(
		.WIDTH(IO_COUNT),
		.ADDRESS(peripheralPkg::OE_OFFSET),
		.DEFAULT('0)
	) oeRegister (
		.clk(clk),
		.reset(reset),
		.localBus(localBus),
		.dataRead(oeData),
		.request(oeRequest),
		.currentValue(gpioOe) // pins start undriven
	);

	ConfigurationRegister #(
		.WIDTH(IO_COUNT),
		.ADDRESS(peripheralPkg::OUTPUT_OFFSET),
		.DEFAULT('0)
	) outputRegister (
		.clk(clk),
		.reset(reset),
		.localBus(localBus),
		.dataRead(outputData),
		.request(outputRequest),
		.currentValue(gpioOutput)
	);

	DataRegister #(
		.WIDTH(IO_COUNT),
		.ADDRESS(peripheralPkg::INPUT_OFFSET)
	) inputRegister (
		.clk(clk),
		.reset(reset),
		.localBus(localBus),
		.readData(gpioInput),
		.readEnable(), // nothing to pop on a pin read
		.dataRead(inputData),
		.request(inputRequest)
	);

	// ******************************
	// read-back selection
	// ******************************
	assign peripheralBus.request = oeRequest || outputRequest || inputRequest;

	assign peripheralBus.dataRead = oeRequest ? oeData :
		outputRequest ? outputData :
		inputRequest ? inputData :
		'0;

endmodule

// ==== hdl/PeripheralSubsystem.sv ====
module PeripheralSubsystem (
	input logic clk,
	input logic reset,

	input logic peripheralEnable,
	input logic peripheralWe,
	input logic peripheralOe,
	input peripheralPkg::busAddress_t peripheralAddress,
	input peripheralPkg::byteSelect_t peripheralByteSelect,
	input peripheralPkg::busData_t peripheralDataWrite,
	output peripheralPkg::busData_t peripheralDataRead,
	output logic peripheralRequest,

	input logic [peripheralPkg::GPIO0_IO_COUNT-1:0] gpio0Input,
	output logic [peripheralPkg::GPIO0_IO_COUNT-1:0] gpio0Output,
	output logic [peripheralPkg::GPIO0_IO_COUNT-1:0] gpio0Oe,

	input logic [peripheralPkg::GPIO1_IO_COUNT-1:0] gpio1Input,
	output logic [peripheralPkg::GPIO1_IO_COUNT-1:0] gpio1Output,
	output logic [peripheralPkg::GPIO1_IO_COUNT-1:0] gpio1Oe
);

	peripheralBusIf gpio0Bus ();
	peripheralBusIf gpio1Bus ();

	// ******************************
	// host side fan-out
	// ******************************
	assign gpio0Bus.enable = peripheralEnable;
	assign gpio0Bus.we = peripheralWe;
	assign gpio0Bus.oe = peripheralOe;
	assign gpio0Bus.address = peripheralAddress;
	assign gpio0Bus.byteSelect = peripheralByteSelect;
	assign gpio0Bus.dataWrite = peripheralDataWrite;

	assign gpio1Bus.enable = peripheralEnable;
	assign gpio1Bus.we = peripheralWe;
	assign gpio1Bus.oe = peripheralOe;
	assign gpio1Bus.address = peripheralAddress;
	assign gpio1Bus.byteSelect = peripheralByteSelect;
	assign gpio1Bus.dataWrite = peripheralDataWrite;

	GPIODevice #(
		.ID(peripheralPkg::GPIO0_ID),
		.IO_COUNT(peripheralPkg::GPIO0_IO_COUNT)
	) gpio0 (
		.clk(clk),
		.reset(reset),
		.peripheralBus(gpio0Bus),
		.gpioInput(gpio0Input),
		.gpioOutput(gpio0Output),
		.gpioOe(gpio0Oe)
	);

	GPIODevice #(
		.ID(peripheralPkg::GPIO1_ID),
		.IO_COUNT(peripheralPkg::GPIO1_IO_COUNT)
	) gpio1 (
		.clk(clk),
		.reset(reset),
		.peripheralBus(gpio1Bus),
		.gpioInput(gpio1Input),
		.gpioOutput(gpio1Output),
		.gpioOe(gpio1Oe)
	);

	// ******************************
	// read data merge
	// ******************************
	assign peripheralRequest = gpio0Bus.request || gpio1Bus.request; // only one device answers

	assign peripheralDataRead = gpio0Bus.request ? gpio0Bus.dataRead :
		gpio1Bus.request ? gpio1Bus.dataRead :
		'0;

endmodule

// ==== hdl/peripheralPkg.sv ====
package peripheralPkg;

	// ******************************
	// bus geometry
	// ******************************
	localparam int DATA_WIDTH = 32;
	localparam int ADDRESS_WIDTH = 16;
	localparam int LOCAL_ADDRESS_WIDTH = 12;
	localparam int DEVICE_ID_WIDTH = 4; // the ID nibble sits in address bits 15 to 12
	localparam int BYTE_LANES = 4;

	typedef logic [DATA_WIDTH-1:0] busData_t;
	typedef logic [ADDRESS_WIDTH-1:0] busAddress_t;
	typedef logic [LOCAL_ADDRESS_WIDTH-1:0] localAddress_t;
	typedef logic [BYTE_LANES-1:0] byteSelect_t;
	typedef logic [DEVICE_ID_WIDTH-1:0] deviceId_t;

	// ******************************
	// GPIO register map and devices
	// ******************************
	localparam localAddress_t OE_OFFSET = 12'h000;
	localparam localAddress_t OUTPUT_OFFSET = 12'h004;
	localparam localAddress_t INPUT_OFFSET = 12'h008; // read only

	localparam deviceId_t GPIO0_ID = 4'h0;
	localparam deviceId_t GPIO1_ID = 4'h1;
	localparam int GPIO0_IO_COUNT = 16;
	localparam int GPIO1_IO_COUNT = 8;

endpackage

// ==== tests/PeripheralSubsystemTb.sv ====
module PeripheralSubsystemTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TRANSFER_COUNT = 4 + 8 + 32 + 10 + 10; // reads and writes of all tests

	typedef logic [peripheralPkg::GPIO0_IO_COUNT-1:0] pins_t; // widest pin vector

	logic clk;
	logic reset;
	logic peripheralEnable;
	logic peripheralWe;
	logic peripheralOe;
	peripheralPkg::busAddress_t peripheralAddress;
	peripheralPkg::byteSelect_t peripheralByteSelect;
	peripheralPkg::busData_t peripheralDataWrite;
	peripheralPkg::busData_t peripheralDataRead;
	logic peripheralRequest;
	logic [peripheralPkg::GPIO0_IO_COUNT-1:0] gpio0Input;
	logic [peripheralPkg::GPIO0_IO_COUNT-1:0] gpio0Output;
	logic [peripheralPkg::GPIO0_IO_COUNT-1:0] gpio0Oe;
	logic [peripheralPkg::GPIO1_IO_COUNT-1:0] gpio1Input;
	logic [peripheralPkg::GPIO1_IO_COUNT-1:0] gpio1Output;
	logic [peripheralPkg::GPIO1_IO_COUNT-1:0] gpio1Oe;

	peripheralPkg::busData_t regModel [2][2]; // [device][0 = OE, 1 = output]
	logic [31:0] lfsrState = 32'h8bb6;
	int testErrors;
	int passCount;
	int failCount;

	PeripheralSubsystem DUT (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ******************************
	// helpers
	// ******************************
	function automatic peripheralPkg::busData_t randomBits(int count);
		peripheralPkg::busData_t value;
		logic feedback;
		value = '0;
		for (int i = 0; i < count; i++) begin
			feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]; // x^32+x^22+x^2+x+1
			lfsrState = {lfsrState[30:0], feedback};
			value = {value[30:0], feedback};
		end
		return value;
	endfunction

	function automatic peripheralPkg::busData_t maskTo(peripheralPkg::busData_t value, int dev);
		int ioCount;
		ioCount = dev ? peripheralPkg::GPIO1_IO_COUNT : peripheralPkg::GPIO0_IO_COUNT;
		return value & ((peripheralPkg::busData_t'(1) << ioCount) - 1);
	endfunction

	function automatic peripheralPkg::busAddress_t regAddress(int dev,
		peripheralPkg::localAddress_t offset);
		peripheralPkg::deviceId_t id;
		id = dev ? peripheralPkg::GPIO1_ID : peripheralPkg::GPIO0_ID;
		return {id, offset};
	endfunction

	function automatic peripheralPkg::localAddress_t regOffset(int r);
		return r ? peripheralPkg::OUTPUT_OFFSET : peripheralPkg::OE_OFFSET;
	endfunction

	function automatic pins_t pinsOf(int dev, int r);
		if (dev == 0) begin
			return r ? gpio0Output : gpio0Oe;
		end
		return r ? pins_t'(gpio1Output) : pins_t'(gpio1Oe);
	endfunction

	task automatic nextCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic driveBus(logic we, logic oe, peripheralPkg::busAddress_t address,
		peripheralPkg::byteSelect_t byteSelect, peripheralPkg::busData_t data);
		peripheralEnable = we || oe;
		peripheralWe = we;
		peripheralOe = oe;
		peripheralAddress = address;
		peripheralByteSelect = byteSelect;
		peripheralDataWrite = data;
	endtask

	task automatic busWrite(peripheralPkg::busAddress_t address,
		peripheralPkg::byteSelect_t byteSelect, peripheralPkg::busData_t data);
		driveBus(1'b1, 1'b0, address, byteSelect, data);
		nextCycle();
		driveBus(1'b0, 1'b0, '0, '0, '0);
	endtask

	task automatic busRead(peripheralPkg::busAddress_t address,
		output peripheralPkg::busData_t data, output logic gotRequest);
		driveBus(1'b0, 1'b1, address, '0, '0);
		nextCycle();
		driveBus(1'b0, 1'b0, '0, '0, '0);
		data = peripheralDataRead; // request and data are flops, settled 1 ns after the edge
		gotRequest = peripheralRequest;
	endtask

	// ******************************
	// checks
	// ******************************
	task automatic compareData(string name, peripheralPkg::busData_t expected,
		peripheralPkg::busData_t actual);
		if (actual !== expected) begin
			$display("ERR %s: expected %h, actual %h", name, expected, actual);
			testErrors++;
		end
	endtask

	task automatic comparePins(string name, pins_t expected, pins_t actual);
		if (actual !== expected) begin
			$display("ERR %s: expected pins %h, actual %h", name, expected, actual);
			testErrors++;
		end
	endtask

	task automatic checkRead(string name, peripheralPkg::busAddress_t address,
		peripheralPkg::busData_t expected);
		peripheralPkg::busData_t data;
		logic gotRequest;
		busRead(address, data, gotRequest);
		if (gotRequest !== 1'b1) begin
			$display("%s: no request in the cycle after the read of %h", name, address);
			testErrors++;
		end else begin
			compareData(name, expected, data);
		end
	endtask

	task automatic checkNoRead(string name, peripheralPkg::busAddress_t address);
		peripheralPkg::busData_t data;
		logic gotRequest;
		busRead(address, data, gotRequest);
		if (gotRequest !== 1'b0) begin
			$display("%s: a read of unmapped address %h raised a request", name, address);
			testErrors++;
		end
		compareData(name, '0, data);
	endtask

	task automatic checkDevice(string name, int dev);
		for (int r = 0; r < 2; r++) begin
			checkRead(name, regAddress(dev, regOffset(r)), regModel[dev][r]);
			comparePins(name, pins_t'(regModel[dev][r]), pinsOf(dev, r));
		end
	endtask

	task automatic finishTest(string name);
		if (testErrors == 0) begin
			$display("%s: ok", name);
			passCount++;
		end else begin
			$display("%s: %0d errors", name, testErrors);
			failCount++;
		end
		testErrors = 0;
	endtask

	// ******************************
	// directed tests
	// ******************************
	task automatic testReset();
		checkDevice("reset", 0);
		checkDevice("reset", 1);
		finishTest("reset");
	endtask

	task automatic testFullWrites();
		peripheralPkg::busData_t value;
		for (int dev = 0; dev < 2; dev++) begin
			for (int r = 0; r < 2; r++) begin
				value = randomBits(32);
				busWrite(regAddress(dev, regOffset(r)), 4'hf, value);
				regModel[dev][r] = maskTo(value, dev);
				comparePins("full writes", pins_t'(regModel[dev][r]), pinsOf(dev, r));
				checkRead("full writes", regAddress(dev, regOffset(r)), regModel[dev][r]);
			end
		end
		finishTest("full writes");
	endtask

	task automatic testByteLanes();
		peripheralPkg::busData_t value;
		peripheralPkg::busData_t expected;
		for (int dev = 0; dev < 2; dev++) begin
			for (int r = 0; r < 2; r++) begin
				for (int lane = 0; lane < peripheralPkg::BYTE_LANES; lane++) begin
					value = randomBits(32);
					busWrite(regAddress(dev, regOffset(r)), 4'b0001 << lane, value);
					expected = regModel[dev][r];
					expected[lane*8 +: 8] = value[lane*8 +: 8];
					regModel[dev][r] = maskTo(expected, dev); // lanes above the pins vanish
					comparePins("byte lanes", pins_t'(regModel[dev][r]), pinsOf(dev, r));
					checkRead("byte lanes", regAddress(dev, regOffset(r)), regModel[dev][r]);
				end
			end
		end
		finishTest("byte lanes");
	endtask

	task automatic testInputs();
		peripheralPkg::busData_t value;
		for (int dev = 0; dev < 2; dev++) begin
			value = randomBits(dev ? peripheralPkg::GPIO1_IO_COUNT : peripheralPkg::GPIO0_IO_COUNT);
			if (dev == 0) begin
				gpio0Input = value[peripheralPkg::GPIO0_IO_COUNT-1:0];
			end else begin
				gpio1Input = value[peripheralPkg::GPIO1_IO_COUNT-1:0];
			end
			checkRead("inputs", regAddress(dev, peripheralPkg::INPUT_OFFSET), value);
			busWrite(regAddress(dev, peripheralPkg::INPUT_OFFSET), 4'hf, randomBits(32));
			checkRead("inputs", regAddress(dev, peripheralPkg::INPUT_OFFSET), value);
			checkDevice("inputs", dev); // the write must not leak into OE or output
		end
		finishTest("inputs");
	endtask

	task automatic testDecoding();
		peripheralPkg::busData_t value;
		peripheralPkg::busData_t firstData;
		logic firstRequest;
		for (int dev = 0; dev < 2; dev++) begin
			value = randomBits(32);
			busWrite(regAddress(dev, peripheralPkg::OUTPUT_OFFSET), 4'hf, value);
			regModel[dev][1] = maskTo(value, dev);
			checkDevice("decoding", 1 - dev);
		end
		checkNoRead("decoding", {4'h2, peripheralPkg::OE_OFFSET});
		checkNoRead("decoding", regAddress(0, 12'h00c));
		driveBus(1'b0, 1'b1, regAddress(0, peripheralPkg::OUTPUT_OFFSET), '0, '0);
		nextCycle();
		firstData = peripheralDataRead;
		firstRequest = peripheralRequest;
		driveBus(1'b0, 1'b1, regAddress(1, peripheralPkg::OUTPUT_OFFSET), '0, '0);
		nextCycle();
		driveBus(1'b0, 1'b0, '0, '0, '0);
		if (firstRequest !== 1'b1 || peripheralRequest !== 1'b1) begin
			$display("decoding: a back-to-back read was not answered in the next cycle");
			testErrors++;
		end else begin
			compareData("decoding", regModel[0][1], firstData);
			compareData("decoding", regModel[1][1], peripheralDataRead);
		end
		finishTest("decoding");
	endtask

	// ******************************
	// run
	// ******************************
	initial begin
		#(TRANSFER_COUNT * 4 * 4);
		$display("timeout: the tests did not finish in %0d ns", TRANSFER_COUNT * 16);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		reset = 1'b1;
		driveBus(1'b0, 1'b0, '0, '0, '0);
		gpio0Input = '0;
		gpio1Input = '0;
		testErrors = 0;
		passCount = 0;
		failCount = 0;
		foreach (regModel[d, r]) begin
			regModel[d][r] = '0;
		end
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		testReset();
		testFullWrites();
		testByteLanes();
		testInputs();
		testDecoding();
		$display("tests passed %0d, failed %0d, assertion failures %0d",
			passCount, failCount, DUT.busChecks.assertFailures);
		if (failCount == 0 && DUT.busChecks.assertFailures == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== tests/PeripheralSubsystemTb_asserts.sv ====
module PeripheralSubsystemAsserts (
	input logic clk,
	input logic reset,
	input logic peripheralEnable,
	input logic peripheralWe,
	input logic peripheralOe,
	input logic peripheralRequest,
	input peripheralPkg::busData_t peripheralDataRead
);
	timeunit 1ns;
	timeprecision 100ps;

	int assertFailures = 0;

	// ******************************
	// bus timing
	// ******************************
	requestAfterReset: assert property (@(posedge clk) reset |=> !peripheralRequest)
		else begin
			assertFailures++;
			$error("request high during reset or in the first cycle after it");
		end

	requestOnlyAfterRead: assert property (@(posedge clk) disable iff (reset)
		peripheralRequest |-> $past(peripheralEnable && peripheralOe && !peripheralWe))
		else begin
			assertFailures++;
			$error("request high without an enabled read in the cycle before");
		end

	quietDataRead: assert property (@(posedge clk) disable iff (reset)
		!peripheralRequest |-> peripheralDataRead == '0)
		else begin
			assertFailures++;
			$error("read data not zero while request is low");
		end

	exclusiveStrobes: assert property (@(posedge clk) !(peripheralWe && peripheralOe))
		else begin
			assertFailures++;
			$error("we and oe high in the same cycle");
		end

endmodule

bind PeripheralSubsystem PeripheralSubsystemAsserts busChecks (
	.clk(clk),
	.reset(reset),
	.peripheralEnable(peripheralEnable),
	.peripheralWe(peripheralWe),
	.peripheralOe(peripheralOe),
	.peripheralRequest(peripheralRequest),
	.peripheralDataRead(peripheralDataRead)
);
